//--- Bender.yml
package:
  name: uart_core

sources:
  - include_dirs:
      - source
    files:
      - source/uart_pkg.sv
      - source/uart_baud_regs.sv
      - source/uart_byte_rx.sv
      - source/uart_byte_tx.sv
      - source/uart_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/clk_gen.sv
      - verification/tb_uart_top.sv

//--- source/uart_baud_regs.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_baud_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_we,
    input  uart_pkg::baud_sel_t     cfg_baud,
    output logic [`UART_DIV_W-1:0]  baud_div
);
    import uart_pkg::*;

    localparam logic [`UART_DIV_W-1:0] div_9600   = `UART_DIV_9600;
    localparam logic [`UART_DIV_W-1:0] div_19200  = `UART_DIV_19200;
    localparam logic [`UART_DIV_W-1:0] div_38400  = `UART_DIV_38400;
    localparam logic [`UART_DIV_W-1:0] div_57600  = `UART_DIV_57600;
    localparam logic [`UART_DIV_W-1:0] div_115200 = `UART_DIV_115200;

    baud_sel_t baud_sel;

    // selection register, written by software
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_sel <= baud_9600;
        end else if (cfg_we) begin
            baud_sel <= cfg_baud;
        end
    end

    // divisor follows the selection one clock later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_div <= div_9600;
        end else begin
            case (baud_sel)
                baud_19200:  baud_div <= div_19200;
                baud_38400:  baud_div <= div_38400;
                baud_57600:  baud_div <= div_57600;
                baud_115200: baud_div <= div_115200;
                default:     baud_div <= div_9600;
            endcase
        end
    end

endmodule

//--- source/uart_byte_rx.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_byte_rx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rx_line,
    input  logic [`UART_DIV_W-1:0]  baud_div,
    output logic                    rx_done,
    output uart_pkg::uart_byte_t    rx_data,
    output logic                    rx_frame_err
);
    import uart_pkg::*;

    localparam logic [7:0] frame_last   = 8'(10 * `UART_OVERSAMPLE - 1);
    localparam logic [7:0] reject_tick  = 8'(`UART_VOTE_HI + 1);
    localparam logic [3:0] vote_lo      = 4'(`UART_VOTE_LO);
    localparam logic [3:0] vote_hi      = 4'(`UART_VOTE_HI);
    localparam logic [2:0] vote_one     = 3'(`UART_VOTE_ONE);
    localparam logic [2:0] start_reject = 3'(`UART_START_REJECT);

    logic [1:0]            sync_q;
    logic [1:0]            hist_q;
    logic                  fall_edge;
    logic                  rx_busy;
    logic [`UART_DIV_W-1:0] div_cnt;
    logic                  tick;
    logic [7:0]            tick_cnt;
    logic [3:0]            bit_idx;
    logic [3:0]            phase;
    logic                  in_window;
    logic                  frame_start;
    logic                  false_start;
    logic                  stop_ok;
    logic [2:0]            acc [0:9];
    uart_byte_t            vote_byte;

    //////////////////////////////////////////////////
    // line synchronizer and start edge
    //////////////////////////////////////////////////

    // idle line is high, so come out of reset high too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b11;
            hist_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rx_line};
            hist_q <= {hist_q[0], sync_q[1]};
        end
    end

    assign fall_edge   = hist_q[1] & ~hist_q[0];
    assign frame_start = ~rx_busy & fall_edge;

    //////////////////////////////////////////////////
    // tick position and vote window
    //////////////////////////////////////////////////

    assign tick = rx_busy && (div_cnt == baud_div);

    // 16 ticks per bit, so the upper nibble is the bit number
    assign bit_idx   = tick_cnt[7:4];
    assign phase     = tick_cnt[3:0];
    assign in_window = tick && (phase >= vote_lo) && (phase <= vote_hi);

    // start samples are complete once the count reaches tick 12
    assign false_start = rx_busy && (tick_cnt == reject_tick) && (acc[0] >= start_reject);

    always_ff @(posedge clk) begin
        if (frame_start) begin
            for (int i = 0; i < 10; i++) begin
                acc[i] <= '0;
            end
        end else if (in_window) begin
            acc[bit_idx] <= acc[bit_idx] + {2'b00, sync_q[1]};
        end
    end

    // acc[1] holds bit 0, acc[9] the stop bit
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            vote_byte[i] = (acc[i + 1] >= vote_one);
        end
    end

    assign stop_ok = (acc[9] >= vote_one);

    //////////////////////////////////////////////////
    // frame control
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_busy      <= 1'b0;
            div_cnt      <= '0;
            tick_cnt     <= '0;
            rx_done      <= 1'b0;
            rx_frame_err <= 1'b0;
            rx_data      <= '0;
        end else begin
            rx_done      <= 1'b0;
            rx_frame_err <= 1'b0;
            if (!rx_busy) begin
                // divider parked at zero so its phase starts at the edge
                div_cnt  <= '0;
                tick_cnt <= '0;
                if (fall_edge) begin
                    rx_busy <= 1'b1;
                end
            end else if (false_start) begin
                rx_busy <= 1'b0;
            end else if (tick) begin
                div_cnt <= '0;
                if (tick_cnt == frame_last) begin
                    rx_busy <= 1'b0;
                    if (stop_ok) begin
                        rx_done <= 1'b1;
                        rx_data <= vote_byte;
                    end else begin
                        rx_frame_err <= 1'b1;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 8'd1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- source/uart_byte_tx.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_byte_tx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`UART_DIV_W-1:0]  baud_div,
    input  logic                    tx_start,
    input  uart_pkg::uart_byte_t    tx_data,
    output logic                    tx_busy,
    output logic                    tx_line
);

    localparam logic [3:0] tick_last = 4'(`UART_OVERSAMPLE - 1);
    // start, eight data bits, stop
    localparam logic [3:0] bit_last  = 4'd9;

    logic [9:0]             frame;
    logic [`UART_DIV_W-1:0] div_cnt;
    logic [3:0]             tick_cnt;
    logic [3:0]             bit_cnt;
    logic                   accept;

    // a start pulse while busy is dropped
    assign accept = tx_start & ~tx_busy;

    //////////////////////////////////////////////////
    // frame shifter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame    <= '1;
            tx_busy  <= 1'b0;
            div_cnt  <= '0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (accept) begin
            frame    <= {1'b1, tx_data, 1'b0};
            tx_busy  <= 1'b1;
            div_cnt  <= '0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (tx_busy) begin
            if (div_cnt == baud_div) begin
                div_cnt <= '0;
                if (tick_cnt == tick_last) begin
                    // end of bit, ones fill in behind the stop bit
                    tick_cnt <= '0;
                    frame    <= {1'b1, frame[9:1]};
                    bit_cnt  <= bit_cnt + 4'd1;
                    if (bit_cnt == bit_last) begin
                        tx_busy <= 1'b0;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 4'd1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // frame is all ones when idle
    assign tx_line = frame[0];

endmodule

//--- source/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// system clock of 10 MHz to match the 100 ns period
`define UART_CLK_HZ 10000000

// oversample ticks per bit
`define UART_OVERSAMPLE 16

// clocks per tick minus one for each baud rate
`define UART_DIV_9600   64
`define UART_DIV_19200  31
`define UART_DIV_38400  15
`define UART_DIV_57600  10
`define UART_DIV_115200 4
`define UART_DIV_W      16

// first and last sampled tick inside each bit
`define UART_VOTE_LO 6
`define UART_VOTE_HI 11

// start bit with this many high samples is treated as noise
`define UART_START_REJECT 3
// high samples needed for a one
`define UART_VOTE_ONE 4

`endif

//--- source/uart_pkg.sv
package uart_pkg;

    //////////////////////////////////////////////////
    // baud selection
    //////////////////////////////////////////////////

    // codes 5 to 7 are unused and decode as 9600
    typedef enum logic [2:0] {
        baud_9600   = 3'd0,
        baud_19200  = 3'd1,
        baud_38400  = 3'd2,
        baud_57600  = 3'd3,
        baud_115200 = 3'd4
    } baud_sel_t;

    //////////////////////////////////////////////////
    // data
    //////////////////////////////////////////////////

    // one payload byte, sent LSB first
    typedef logic [7:0] uart_byte_t;

endpackage

//--- source/uart_top.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // configuration
    input  logic                    cfg_we,
    input  uart_pkg::baud_sel_t     cfg_baud,
    // transmit side
    input  logic                    tx_start,
    input  uart_pkg::uart_byte_t    tx_data,
    output logic                    tx_busy,
    output logic                    tx_line,
    // receive side
    input  logic                    rx_line,
    output logic                    rx_done,
    output uart_pkg::uart_byte_t    rx_data,
    output logic                    rx_frame_err
);

    // one divisor shared by both directions
    logic [`UART_DIV_W-1:0] baud_div;

    uart_baud_regs u_baud_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_we   (cfg_we),
        .cfg_baud (cfg_baud),
        .baud_div (baud_div)
    );

    uart_byte_tx u_byte_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .baud_div (baud_div),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .tx_line  (tx_line)
    );

    uart_byte_rx u_byte_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_line      (rx_line),
        .baud_div     (baud_div),
        .rx_done      (rx_done),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err)
    );

endmodule

//--- tb.f
+incdir+source
source/uart_pkg.sv
source/uart_baud_regs.sv
source/uart_byte_rx.sv
source/uart_byte_tx.sv
source/uart_top.sv
verification/clk_gen.sv
verification/tb_uart_top.sv

//--- verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // reset held low for 8 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- verification/tb_uart_top.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_top;
    import uart_pkg::*;

    localparam int num_rows    = 10;
    localparam int mode_loop   = 0;
    localparam int mode_clean  = 1;
    localparam int mode_glitch = 2;
    localparam int mode_false  = 3;
    localparam int mode_stop   = 4;
    localparam int mode_busy   = 5;

    logic       clk, rst_n, cfg_we, tx_start, tx_busy, tx_line;
    logic       rx_line, rx_done, rx_frame_err, line_drv, loop_en;
    baud_sel_t  cfg_baud;
    uart_byte_t tx_data, rx_data, last_good;
    int         seed, done_cnt, err_cnt, cycle_cnt, cycle_limit;

    // stimulus table: baud, mode, byte, good frame expected
    baud_sel_t  row_baud [num_rows];
    int         row_mode [num_rows];
    uart_byte_t row_data [num_rows];
    logic       row_good [num_rows];

    assign rx_line = loop_en ? tx_line : line_drv;

    clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    uart_top DUT (
        .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_baud(cfg_baud),
        .tx_start(tx_start), .tx_data(tx_data), .tx_busy(tx_busy), .tx_line(tx_line),
        .rx_line(rx_line), .rx_done(rx_done), .rx_data(rx_data),
        .rx_frame_err(rx_frame_err)
    );

    //////////////////////////////////////////////////
    // monitor and watchdog
    //////////////////////////////////////////////////

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rx_done) done_cnt++;
        if (rx_frame_err) err_cnt++;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: receiver gave no result within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail %0t ns: %s counted %0d, expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////
    // timing and line driver
    //////////////////////////////////////////////////

    // divisor table of the config header, plus one
    function automatic int tick_clocks(input baud_sel_t b);
        case (b)
            baud_19200:  return `UART_DIV_19200 + 1;
            baud_38400:  return `UART_DIV_38400 + 1;
            baud_57600:  return `UART_DIV_57600 + 1;
            baud_115200: return `UART_DIV_115200 + 1;
            default:     return `UART_DIV_9600 + 1;
        endcase
    endfunction

    function automatic int bit_clocks(input baud_sel_t b);
        return `UART_OVERSAMPLE * tick_clocks(b);
    endfunction

    // idle bits watched after a result, a whole frame for the busy case
    function automatic int guard_bits(input int mode);
        return (mode == mode_busy) ? 10 : 2;
    endfunction

    function automatic int run_budget();
        int total;
        total = 28 + 10 * bit_clocks(baud_9600);
        for (int i = 0; i < num_rows; i++) begin
            total += (10 + guard_bits(row_mode[i]) + ((row_mode[i] == mode_false) ? 2 : 0))
                     * bit_clocks(row_baud[i]) + 20;
        end
        return total + total / 5;
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) step();
    endtask

    task automatic drive_level(input logic v, input int n);
        line_drv = v;
        wait_clocks(n);
    endtask

    // slots 8 and 11 of a masked bit land on sampled ticks 7 and 10
    task automatic drive_frame(input uart_byte_t data, input uart_byte_t mask,
                               input logic stop, input int tclk);
        logic [9:0] bits;
        logic [9:0] flip;
        bits = {stop, data, 1'b0};
        flip = {1'b0, mask, 1'b0};
        for (int b = 0; b < 10; b++) begin
            for (int s = 0; s < `UART_OVERSAMPLE; s++) begin
                if (flip[b] && (s == 8 || s == 11)) begin
                    drive_level(~bits[b], tclk);
                end else begin
                    drive_level(bits[b], tclk);
                end
            end
        end
        line_drv = 1'b1;
    endtask

    task automatic set_baud(input baud_sel_t b);
        cfg_baud = b;
        cfg_we   = 1'b1;
        step();
        cfg_we   = 1'b0;
        wait_clocks(2);
    endtask

    task automatic send_byte(input uart_byte_t data);
        tx_data  = data;
        tx_start = 1'b1;
        step();
        tx_start = 1'b0;
    endtask

    task automatic wait_result(input int base_done, input int base_err);
        while (done_cnt == base_done && err_cnt == base_err) @(negedge clk);
        step();
    endtask

    //////////////////////////////////////////////////
    // table rows
    //////////////////////////////////////////////////

    task automatic set_row(input int i, input baud_sel_t b, input int mode,
                           input uart_byte_t data, input logic good);
        row_baud[i] = b;
        row_mode[i] = mode;
        row_data[i] = data;
        row_good[i] = good;
    endtask

    task automatic load_table();
        set_row(0, baud_9600,   mode_loop,   uart_byte_t'($random(seed)), 1'b1);
        set_row(1, baud_19200,  mode_loop,   uart_byte_t'($random(seed)), 1'b1);
        set_row(2, baud_38400,  mode_loop,   uart_byte_t'($random(seed)), 1'b1);
        set_row(3, baud_57600,  mode_loop,   uart_byte_t'($random(seed)), 1'b1);
        set_row(4, baud_115200, mode_loop,   uart_byte_t'($random(seed)), 1'b1);
        set_row(5, baud_115200, mode_clean,  8'hA5, 1'b1);
        set_row(6, baud_57600,  mode_glitch, 8'h3C, 1'b1);
        set_row(7, baud_115200, mode_false,  8'h96, 1'b1);
        set_row(8, baud_115200, mode_stop,   8'h5A, 1'b0);
        set_row(9, baud_38400,  mode_busy,   uart_byte_t'($random(seed)), 1'b1);
    endtask

    task automatic run_row(input int i);
        int         base_done;
        int         base_err;
        int         tclk;
        uart_byte_t exp_data;
        tclk = tick_clocks(row_baud[i]);
        set_baud(row_baud[i]);
        base_done = done_cnt;
        base_err  = err_cnt;
        case (row_mode[i])
            mode_clean:  drive_frame(row_data[i], 8'h00, 1'b1, tclk);
            mode_glitch: drive_frame(row_data[i], 8'b0110_1011, 1'b1, tclk);
            mode_stop:   drive_frame(row_data[i], 8'h00, 1'b0, tclk);
            mode_false: begin
                // five low ticks, then idle past the start check
                drive_level(1'b0, 5 * tclk);
                drive_level(1'b1, 16 * tclk);
                check_count(done_cnt - base_done, 0, "rx_done after false start");
                check_count(err_cnt - base_err, 0, "rx_frame_err after false start");
                drive_frame(row_data[i], 8'h00, 1'b1, tclk);
            end
            mode_busy: begin
                loop_en = 1'b1;
                send_byte(row_data[i]);
                wait_clocks(3 * `UART_OVERSAMPLE * tclk);
                check_flag(tx_busy, 1'b1, "tx_busy mid frame");
                send_byte(~row_data[i]);
            end
            default: begin
                loop_en = 1'b1;
                send_byte(row_data[i]);
            end
        endcase
        wait_result(base_done, base_err);
        wait_clocks(guard_bits(row_mode[i]) * bit_clocks(row_baud[i]));
        exp_data = row_good[i] ? row_data[i] : last_good;
        check_count(done_cnt - base_done, row_good[i] ? 1 : 0, "rx_done pulses");
        check_count(err_cnt - base_err, row_good[i] ? 0 : 1, "rx_frame_err pulses");
        check_byte(rx_data, exp_data, "rx_data");
        check_flag(tx_busy, 1'b0, "tx_busy after frame");
        loop_en = 1'b0;
        if (row_good[i]) last_good = row_data[i];
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        cfg_we    = 1'b0;
        cfg_baud  = baud_9600;
        tx_start  = 1'b0;
        tx_data   = '0;
        line_drv  = 1'b1;
        loop_en   = 1'b0;
        done_cnt  = 0;
        err_cnt   = 0;
        cycle_cnt = 0;
        last_good = '0;
        seed      = 26;
        load_table();
        cycle_limit = run_budget();
        wait (rst_n === 1'b1);
        step();
        check_flag(tx_line, 1'b1, "tx_line after reset");
        check_flag(tx_busy, 1'b0, "tx_busy after reset");
        check_byte(rx_data, 8'h00, "rx_data after reset");
        // idle line for one frame, nothing may arrive
        wait_clocks(10 * bit_clocks(baud_9600));
        check_count(done_cnt, 0, "rx_done while idle");
        check_count(err_cnt, 0, "rx_frame_err while idle");
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
